/* sources.f */
+incdir+include
logic/freq_meter_pkg.sv
logic/gate_timer.sv
logic/gate_synchronizer.sv
logic/step_accumulator.sv
logic/frequency_counter.sv
verification/frequency_counter_tb.sv

/* run.sh */
#!/bin/sh
# build and run the frequency counter testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module frequency_counter_tb -o frequency_counter_tb_sim > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }

./obj_dir/frequency_counter_tb_sim > sim.log 2>&1
cat sim.log
grep -q "tests failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "all tests passed" sim.log || { echo "FAIL: run ended without a result"; exit 1; }
echo "PASS"

/* verification/frequency_counter_tb.sv */
// ******************************
// frequency counter testbench
// sweeps the reference period and
// checks the published frequency
// ******************************

`timescale 1ns/1ps
`default_nettype none

`include "freq_meter_config.svh"

module frequency_counter_tb;

	localparam int row_count = 5;

	// reference cycles in one full measurement period, gate open for half
	localparam int measurement_ref_cycles = 1 << (`FM_GATE_LOG2 + 1);

	localparam int unknown_period_ps = 4000;
	localparam int slowest_period_ps = 200000;

	// one count of the sum is worth FM_STEP, one unknown cycle of
	// jitter on each gate edge moves the result by about this much
	localparam int result_tolerance = `FM_STEP / (1 << `FM_GATE_LOG2) + 2;

	// two discarded and one checked result, then a 3.5 period window,
	// all at the slowest reference and doubled for margin
	localparam int timeout_cycles = 2 * row_count * 7 * measurement_ref_cycles
		* (slowest_period_ps / unknown_period_ps);

	// pulses expected in a window of 3.5 measurement periods
	localparam int pulses_per_window = 3;

	logic unknown_clock;
	logic reference_clock;
	logic reset;

	freq_meter_pkg::result_t frequency;
	logic valid;
	logic overrange;

	// reference period in ps per row
	int unsigned period_table [row_count] = '{100000, 80000, 125000, 50000, 200000};

	// 250 MHz * (period / 100 ns) / FM_N
	freq_meter_pkg::result_t expected_table [row_count] =
		'{2500000, 2000000, 3125000, 1250000, 5000000};

	freq_meter_pkg::result_t tolerance_table [row_count] = '{
		result_tolerance, result_tolerance, result_tolerance,
		result_tolerance, result_tolerance
	};

	real ref_half_ns = 50.0;
	int cycle_count = 0;
	int error_count = 0;
	int row;
	int pulses;

	frequency_counter UUT (
		.unknown_clock   (unknown_clock),
		.reference_clock (reference_clock),
		.reset           (reset),
		.frequency       (frequency),
		.valid           (valid),
		.overrange       (overrange)
	);

	// 250 MHz clock under test
	initial begin
		unknown_clock = 1'b0;
		forever #2 unknown_clock = ~unknown_clock;
	end

	// reference follows the current row
	// odd offset keeps its edges off the unknown_clock edges
	initial begin
		reference_clock = 1'b0;
		#1.3;
		forever begin
			reference_clock = ~reference_clock;
			#(ref_half_ns);
		end
	end

	// run limit
	always @(posedge unknown_clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("Timeout at %0t: no valid pulse arrived within %0d cycles",
				$time, timeout_cycles);
			$display("tests failed");
			$fatal(1, "cycle limit reached");
		end
	end

	task automatic check_result(
		input freq_meter_pkg::result_t actual,
		input freq_meter_pkg::result_t expected,
		input freq_meter_pkg::result_t tolerance,
		input string what
	);
		freq_meter_pkg::result_t difference;
		if (actual > expected) begin
			difference = actual - expected;
		end else begin
			difference = expected - actual;
		end
		if (difference > tolerance) begin
			error_count++;
			$display("Mismatch at %0t: %s is %0d, expected %0d within %0d",
				$time, what, actual, expected, tolerance);
			$display("tests failed");
			$fatal(1, "result check");
		end
	endtask

	task automatic check_flag(input logic actual, input logic expected, input string what);
		if (actual !== expected) begin
			error_count++;
			$display("Mismatch at %0t: %s is %b, expected %b", $time, what, actual, expected);
			$display("tests failed");
			$fatal(1, "flag check");
		end
	endtask

	task automatic check_count(input int actual, input int expected, input string what);
		if (actual != expected) begin
			error_count++;
			$display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
			$display("tests failed");
			$fatal(1, "count check");
		end
	endtask

	// returns at the falling edge where valid is seen high
	task automatic wait_valid_pulse();
		do begin
			@(negedge unknown_clock);
		end while (valid !== 1'b1);
	endtask

	// 3.5 measurement periods of unknown cycles for a reference period
	function automatic int window_cycles(input int unsigned period_ps);
		longint unsigned measurement_cycles;
		measurement_cycles = (longint'(measurement_ref_cycles) * period_ps) / unknown_period_ps;
		return int'(measurement_cycles * 7 / 2);
	endfunction

	// counts rising valid and flags any pulse longer than a cycle
	task automatic count_pulses(input int cycles, output int count);
		logic previous_valid;
		count = 0;
		previous_valid = valid;
		repeat (cycles) begin
			@(negedge unknown_clock);
			check_flag(valid & previous_valid, 1'b0, "valid held for two cycles");
			if (valid && !previous_valid) begin
				count++;
				check_flag(overrange, 1'b0, "overrange in window");
			end
			previous_valid = valid;
		end
	endtask

	initial begin
		reset = 1'b1;
		ref_half_ns = period_table[0] / 2000.0;
		repeat (10) @(negedge unknown_clock);
		reset = 1'b0;

		// quiet outputs until the first publish
		while (valid !== 1'b1) begin
			check_result(frequency, '0, '0, "frequency before first result");
			check_flag(overrange, 1'b0, "overrange before first result");
			@(negedge unknown_clock);
		end
		check_flag(overrange, 1'b0, "overrange on first result");

		for (row = 0; row < row_count; row++) begin
			ref_half_ns = period_table[row] / 2000.0;

			// first results may span the period change
			wait_valid_pulse();
			wait_valid_pulse();
			wait_valid_pulse();

			$display("row %0d: reference %0d ps, frequency %0d, expected %0d",
				row, period_table[row], frequency, expected_table[row]);
			check_result(frequency, expected_table[row], tolerance_table[row],
				"measured frequency");
			check_flag(overrange, 1'b0, "overrange");

			count_pulses(window_cycles(period_table[row]), pulses);
			check_count(pulses, pulses_per_window, "valid pulses in window");
		end

		if (error_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* logic/frequency_counter.sv */
// ******************************
// frequency counter top
// measures unknown_clock against
// a known reference clock
// ******************************

`timescale 1ns/1ps
`default_nettype none

module frequency_counter (
	input  logic                     unknown_clock,
	input  logic                     reference_clock,
	input  logic                     reset,
	output freq_meter_pkg::result_t  frequency,
	output logic                     valid,
	output logic                     overrange
);

	// reference domain
	logic gate_level;

	// unknown clock domain
	logic gate_open;
	logic gate_opening;
	logic gate_closing;

	// divider and gate in the reference domain
	gate_timer timer (
		.reference_clock (reference_clock),
		.reset           (reset),
		.gate_level      (gate_level)
	);

	// only the gate level crosses the clock boundary
	gate_synchronizer synchronizer (
		.unknown_clock (unknown_clock),
		.reset         (reset),
		.gate_level    (gate_level),
		.gate_open     (gate_open),
		.gate_opening  (gate_opening),
		.gate_closing  (gate_closing)
	);

	// counting and publishing on unknown_clock
	step_accumulator accumulator (
		.unknown_clock (unknown_clock),
		.reset         (reset),
		.gate_open     (gate_open),
		.gate_opening  (gate_opening),
		.gate_closing  (gate_closing),
		.frequency     (frequency),
		.valid         (valid),
		.overrange     (overrange)
	);

endmodule

`default_nettype wire

/* logic/step_accumulator.sv */
// ******************************
// step accumulator
// sums the reference step over the
// gate and publishes the frequency
// ******************************

`timescale 1ns/1ps
`default_nettype none

`include "freq_meter_config.svh"

module step_accumulator (
	input  logic                     unknown_clock,
	input  logic                     reset,
	input  logic                     gate_open,
	input  logic                     gate_opening,
	input  logic                     gate_closing,
	output freq_meter_pkg::result_t  frequency,
	output logic                     valid,
	output logic                     overrange
);

	freq_meter_pkg::gate_state_t state;

	freq_meter_pkg::accumulator_t sum;
	freq_meter_pkg::accumulator_t sum_next;
	freq_meter_pkg::accumulator_t scaled;

	logic too_large;

	// step added on every unknown cycle inside the gate
	always_comb begin
		sum_next = sum;
		if (gate_open) begin
			sum_next = sum + freq_meter_pkg::accumulator_t'(`FM_STEP);
		end
	end

	// divide by the gate length in reference cycles
	assign scaled = sum_next >> `FM_GATE_LOG2;

	// anything above the result word means it does not fit
	assign too_large = |scaled[`FM_ACC_WIDTH-1:`FM_RESULT_WIDTH];

	always_ff @(posedge unknown_clock) begin
		if (reset) begin
			state     <= freq_meter_pkg::gate_idle;
			sum       <= '0;
			frequency <= '0;
			valid     <= 1'b0;
			overrange <= 1'b0;
		end else begin
			valid <= 1'b0;
			case (state)
				// partial gates are dropped, wait for a clean start
				freq_meter_pkg::gate_idle: begin
					sum <= '0;
					if (gate_opening) begin
						state <= freq_meter_pkg::gate_counting;
					end
				end

				freq_meter_pkg::gate_counting: begin
					if (gate_closing) begin
						// last open cycle is included through sum_next
						if (too_large) begin
							frequency <= '1;
						end else begin
							frequency <= scaled[`FM_RESULT_WIDTH-1:0];
						end
						overrange <= too_large;
						valid     <= 1'b1;
						sum       <= '0;
						state     <= freq_meter_pkg::gate_publishing;
					end else begin
						sum <= sum_next;
					end
				end

				// result is on the outputs for this one cycle
				freq_meter_pkg::gate_publishing: begin
					sum   <= '0;
					state <= freq_meter_pkg::gate_idle;
				end

				default: begin
					sum   <= '0;
					state <= freq_meter_pkg::gate_idle;
				end
			endcase
		end
	end

	// one strobe per gate
	valid_single_cycle: assert property (
		@(posedge unknown_clock) disable iff (reset)
		valid |=> !valid
	) else $error("valid held longer than one cycle");

endmodule

`default_nettype wire

/* logic/gate_synchronizer.sv */
// ******************************
// gate synchronizer
// brings the gate level into the
// unknown clock domain with edges
// ******************************

`timescale 1ns/1ps
`default_nettype none

module gate_synchronizer (
	input  logic unknown_clock,
	input  logic reset,
	input  logic gate_level,
	output logic gate_open,
	output logic gate_opening,
	output logic gate_closing
);

	// first stage may go metastable, the rest settle it
	logic [2:0] sync_stages;

	always_ff @(posedge unknown_clock) begin
		if (reset) begin
			sync_stages <= '0;
		end else begin
			sync_stages <= {sync_stages[1:0], gate_level};
		end
	end

	// level seen by the accumulator
	assign gate_open = sync_stages[2];

	// edges one cycle ahead of the level change
	assign gate_opening = sync_stages[1] & ~sync_stages[2];
	assign gate_closing = ~sync_stages[1] & sync_stages[2];

	// a gate shorter than one unknown cycle would break this
	edges_exclusive: assert property (
		@(posedge unknown_clock) disable iff (reset)
		!(gate_opening && gate_closing)
	) else $error("gate opening and closing together");

endmodule

`default_nettype wire

/* logic/gate_timer.sv */
// ******************************
// gate timer
// divides the reference clock and
// drives the measurement gate level
// ******************************

`timescale 1ns/1ps
`default_nettype none

`include "freq_meter_config.svh"

module gate_timer (
	input  logic reference_clock,
	input  logic reset,
	output logic gate_level
);

	// reset carried into the reference domain
	logic [1:0] reset_pipe;
	logic reference_reset;

	freq_meter_pkg::divider_t divider;
	freq_meter_pkg::divider_t divider_next;

	// two flop synchronizer for the reset
	always_ff @(posedge reference_clock) begin
		reset_pipe <= {reset_pipe[0], reset};
	end

	assign reference_reset = reset_pipe[1];

	// free running count, wraps every full measurement period
	assign divider_next = freq_meter_pkg::divider_t'(divider + 1'b1);

	always_ff @(posedge reference_clock) begin
		if (reference_reset) begin
			divider <= '0;
		end else begin
			divider <= divider_next;
		end
	end

	// gate follows the top bit of the count being loaded
	// so the level and the count roll over on the same edge
	always_ff @(posedge reference_clock) begin
		if (reference_reset) begin
			gate_level <= 1'b0;
		end else begin
			gate_level <= divider_next[`FM_GATE_LOG2];
		end
	end

	// the gate edges stay aligned to whole half periods
	// of the divider, which keeps every gate the same length
	gate_edge_on_boundary: assert property (
		@(posedge reference_clock) disable iff (reference_reset)
		$changed(gate_level) |-> (divider[`FM_GATE_LOG2-1:0] == '0)
	) else $error("gate edge away from divider boundary");

endmodule

`default_nettype wire

/* logic/freq_meter_pkg.sv */
// ******************************
// frequency meter package
// vector and state types shared
// by the counter blocks
// ******************************

`default_nettype none

`include "freq_meter_config.svh"

package freq_meter_pkg;

	// measured frequency in units of FM_N Hz
	typedef logic [`FM_RESULT_WIDTH-1:0] result_t;

	// running sum of steps over one gate
	typedef logic [`FM_ACC_WIDTH-1:0] accumulator_t;

	// reference divider, top bit is the gate
	typedef logic [`FM_GATE_LOG2:0] divider_t;

	// accumulator sequence
	typedef enum logic [1:0] {
		gate_idle,
		gate_counting,
		gate_publishing
	} gate_state_t;

endpackage

`default_nettype wire

/* include/freq_meter_config.svh */
// ******************************
// frequency meter constants
// reference rate, result unit and
// gate length for the counter
// ******************************

`ifndef FREQ_METER_CONFIG_SVH
`define FREQ_METER_CONFIG_SVH

// nominal reference clock in Hz
`define FM_REFERENCE_HZ 10000000

// result unit in Hz
`define FM_N 100

// reference rate in result units, added once per unknown cycle
`define FM_STEP (`FM_REFERENCE_HZ / `FM_N)

// gate length is 2**FM_GATE_LOG2 reference cycles
// kept short for simulation
`define FM_GATE_LOG2 8

// published frequency width
`define FM_RESULT_WIDTH 32

// running sum width
// holds several gates at the highest expected rate
`define FM_ACC_WIDTH 64

`endif
